/* common/busPkg.sv */
`default_nettype none

package busPkg;

  // Word and byte-address widths shared by both buses
  localparam int dataWidth = 32;
  localparam int addrWidth = 32;

endpackage

`default_nettype wire

/* common/armPkg.sv */
`default_nettype none

package armPkg;

  localparam int regAddrWidth = 4;
  localparam logic [regAddrWidth-1:0] pcReg = 4'd15;

  // Instruction class, bits 27:26
  localparam logic [1:0] opDp     = 2'b00;
  localparam logic [1:0] opMem    = 2'b01;
  localparam logic [1:0] opBranch = 2'b10;

  // Data-processing command, bits 24:21
  localparam logic [3:0] cmdAnd = 4'h0;
  localparam logic [3:0] cmdSub = 4'h2;
  localparam logic [3:0] cmdAdd = 4'h4;
  localparam logic [3:0] cmdCmp = 4'hA;
  localparam logic [3:0] cmdOrr = 4'hC;
  localparam logic [3:0] cmdMov = 4'hD;

  // Condition 1111 never passes, so this word is a bubble
  localparam logic [31:0] nopInstr = 32'hF000_0000;

  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOrr, aluMov} aluOpT;

  typedef enum logic [1:0] {shLsl, shLsr, shAsr, shRor} shiftT;

  typedef enum logic [3:0] {
    condEq = 4'b0000,
    condNe = 4'b0001,
    condGe = 4'b1010,
    condLt = 4'b1011,
    condAl = 4'b1110
  } condT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef enum logic [1:0] {fwdReg = 2'b00, fwdResultW = 2'b01, fwdAluOutM = 2'b10} fwdSelT;

  typedef enum logic [1:0] {immDp, immMem, immBranch} immSrcT;

endpackage

`default_nettype wire

/* datapath/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  logic                            clk,
  input  logic                            writeEn,
  input  logic [armPkg::regAddrWidth-1:0] readAddr1,
  input  logic [armPkg::regAddrWidth-1:0] readAddr2,
  input  logic [armPkg::regAddrWidth-1:0] writeAddr,
  input  logic [busPkg::dataWidth-1:0]    writeData,
  input  logic [busPkg::dataWidth-1:0]    pcPlus8,
  output logic [busPkg::dataWidth-1:0]    readData1,
  output logic [busPkg::dataWidth-1:0]    readData2
);
  import armPkg::*;
  import busPkg::*;

  logic [dataWidth-1:0] regs [0:14];

  // R15 is not stored here
  always_ff @(posedge clk) begin
    if (writeEn && writeAddr != pcReg) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Same-cycle write wins over the stored value
  assign readData1 = (readAddr1 == pcReg) ? pcPlus8 :
                     (writeEn && readAddr1 == writeAddr) ? writeData : regs[readAddr1];
  assign readData2 = (readAddr2 == pcReg) ? pcPlus8 :
                     (writeEn && readAddr2 == writeAddr) ? writeData : regs[readAddr2];

endmodule

`default_nettype wire

/* datapath/execUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module execUnit (
  input  logic [busPkg::dataWidth-1:0] srcA,
  input  logic [busPkg::dataWidth-1:0] srcB,
  input  logic [23:0]                  immIn,
  input  armPkg::immSrcT               immKind,
  input  logic [6:0]                   instrFields,
  input  armPkg::aluOpT                aluOp,
  input  logic                         shiftEn,
  output logic [busPkg::dataWidth-1:0] immOut,
  output logic [busPkg::dataWidth-1:0] result,
  output armPkg::flagsT                flags
);
  import armPkg::*;
  import busPkg::*;

  logic [4:0]           shAmt;
  shiftT                shType;
  logic [dataWidth-1:0] imm8;
  logic [4:0]           rotAmt;
  logic [dataWidth-1:0] shifted;
  logic [dataWidth-1:0] opB;
  logic [dataWidth:0]   sum;

  assign shAmt  = instrFields[6:2];
  assign shType = shiftT'(instrFields[1:0]);
  assign imm8   = {24'd0, immIn[7:0]};
  assign rotAmt = {immIn[11:8], 1'b0};

  // Immediate forms
  always_comb begin
    case (immKind)
      immDp:     immOut = (imm8 >> rotAmt) | (imm8 << (6'd32 - rotAmt));
      immMem:    immOut = {20'd0, immIn[11:0]};
      immBranch: immOut = {{6{immIn[23]}}, immIn, 2'b00};
      default:   immOut = '0;
    endcase
  end

  // Barrel shifter, zero amount passes the operand through
  always_comb begin
    shifted = srcB;
    if (shiftEn && shAmt != 5'd0) begin
      case (shType)
        shLsl:   shifted = srcB << shAmt;
        shLsr:   shifted = srcB >> shAmt;
        shAsr:   shifted = $signed(srcB) >>> shAmt;
        shRor:   shifted = (srcB >> shAmt) | (srcB << (6'd32 - shAmt));
        default: shifted = srcB;
      endcase
    end
  end

  // Subtract as A + ~B + 1
  assign opB = (aluOp == aluSub) ? ~shifted : shifted;
  assign sum = {1'b0, srcA} + {1'b0, opB} + {{dataWidth{1'b0}}, aluOp == aluSub};

  always_comb begin
    case (aluOp)
      aluAdd, aluSub: result = sum[dataWidth-1:0];
      aluAnd:         result = srcA & shifted;
      aluOrr:         result = srcA | shifted;
      aluMov:         result = shifted;
      default:        result = '0;
    endcase
    flags.n = result[dataWidth-1];
    flags.z = (result == '0);
    flags.c = 1'b0;
    flags.v = 1'b0;
    // C and V only mean something for arithmetic
    if (aluOp == aluAdd || aluOp == aluSub) begin
      flags.c = sum[dataWidth];
      flags.v = (srcA[dataWidth-1] == opB[dataWidth-1]) &&
                (result[dataWidth-1] != srcA[dataWidth-1]);
    end
  end

endmodule

`default_nettype wire

/* datapath/datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module datapath (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [busPkg::dataWidth-1:0] instrF,
  input  armPkg::immSrcT               immSrcD,
  input  logic [1:0]                   regSrcD,
  input  logic                         aluSrcE,
  input  armPkg::aluOpT                aluOpE,
  input  logic                         shiftEnE,
  input  logic                         branchTakenE,
  input  logic                         regWriteW,
  input  logic                         memToRegW,
  input  logic                         stallF,
  input  logic                         stallD,
  input  logic                         flushD,
  input  logic                         flushE,
  input  logic                         stallM,
  input  logic                         flushW,
  input  armPkg::fwdSelT               forwardA,
  input  armPkg::fwdSelT               forwardB,
  input  logic [busPkg::dataWidth-1:0] readDataM,
  output logic [busPkg::addrWidth-1:0] pcF,
  output logic [busPkg::dataWidth-1:0] instrD,
  output logic [busPkg::dataWidth-1:0] aluOutM,
  output logic [busPkg::dataWidth-1:0] writeDataM,
  output armPkg::flagsT                flagsE,
  output logic                         match1EM,
  output logic                         match1EW,
  output logic                         match2EM,
  output logic                         match2EW,
  output logic                         matchDE
);
  import armPkg::*;
  import busPkg::*;

  logic [addrWidth-1:0]    pcPlus4F;
  logic [addrWidth-1:0]    pcNextF;
  logic [regAddrWidth-1:0] ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W;
  logic [dataWidth-1:0]    rd1D, rd2D, rd1E, rd2E;
  logic [23:0]             immFieldE;
  immSrcT                  immSrcE;
  logic [6:0]              shiftFieldsE;
  logic [dataWidth-1:0]    srcAE, writeDataE, immE, srcBE, aluResultE;
  logic [dataWidth-1:0]    aluOutW, resultW;

  // Fetch
  assign pcPlus4F = pcF + 32'd4;
  assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  // Decode
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrD <= nopInstr;
    end else if (flushD) begin
      instrD <= nopInstr;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  assign ra1D = regSrcD[0] ? pcReg : instrD[19:16];
  assign ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0];

  // PC+4 of the fetch stage is PC+8 of the decode instruction
  regFile regs (
    .clk       (clk),
    .writeEn   (regWriteW),
    .readAddr1 (ra1D),
    .readAddr2 (ra2D),
    .writeAddr (wa3W),
    .writeData (resultW),
    .pcPlus8   (pcPlus4F),
    .readData1 (rd1D),
    .readData2 (rd2D)
  );

  // Execute, frozen together with the memory stage
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
    end else if (flushE) begin
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
    end else if (!stallM) begin
      ra1E <= ra1D;
      ra2E <= ra2D;
      wa3E <= instrD[15:12];
    end
  end

  // While frozen, keep forwarded operands since writeback drains to a bubble
  always_ff @(posedge clk) begin
    if (!stallM) begin
      rd1E         <= rd1D;
      rd2E         <= rd2D;
      immFieldE    <= instrD[23:0];
      immSrcE      <= immSrcD;
      shiftFieldsE <= instrD[11:5];
    end else begin
      rd1E <= srcAE;
      rd2E <= writeDataE;
    end
  end

  always_comb begin
    case (forwardA)
      fwdResultW: srcAE = resultW;
      fwdAluOutM: srcAE = aluOutM;
      default:    srcAE = rd1E;
    endcase
    case (forwardB)
      fwdResultW: writeDataE = resultW;
      fwdAluOutM: writeDataE = aluOutM;
      default:    writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcE ? immE : writeDataE;

  execUnit exec (
    .srcA        (srcAE),
    .srcB        (srcBE),
    .immIn       (immFieldE),
    .immKind     (immSrcE),
    .instrFields (shiftFieldsE),
    .aluOp       (aluOpE),
    .shiftEn     (shiftEnE),
    .immOut      (immE),
    .result      (aluResultE),
    .flags       (flagsE)
  );

  // Memory
  always_ff @(posedge clk) begin
    if (!stallM) begin
      aluOutM    <= aluResultE;
      writeDataM <= writeDataE;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wa3M <= '0;
      wa3W <= '0;
    end else begin
      if (!stallM) begin
        wa3M <= wa3E;
      end
      wa3W <= flushW ? '0 : wa3M;
    end
  end

  // Writeback, load data is already held by the bus bridge
  always_ff @(posedge clk) begin
    aluOutW <= aluOutM;
  end

  assign resultW = memToRegW ? readDataM : aluOutW;

  // Register matches for the hazard unit
  assign match1EM = (wa3M == ra1E);
  assign match1EW = (wa3W == ra1E);
  assign match2EM = (wa3M == ra2E);
  assign match2EW = (wa3W == ra2E);
  assign matchDE  = (wa3E == ra1D) || (wa3E == ra2D);

endmodule

`default_nettype wire

/* src/controller.sv */
`timescale 1ns/1ns
`default_nettype none

module controller (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [busPkg::dataWidth-1:0] instrD,
  input  armPkg::flagsT                flagsE,
  input  logic                         match1EM,
  input  logic                         match1EW,
  input  logic                         match2EM,
  input  logic                         match2EW,
  input  logic                         matchDE,
  input  logic                         memBusy,
  output armPkg::immSrcT               immSrcD,
  output logic [1:0]                   regSrcD,
  output logic                         aluSrcE,
  output armPkg::aluOpT                aluOpE,
  output logic                         shiftEnE,
  output logic                         branchTakenE,
  output logic                         regWriteW,
  output logic                         memToRegW,
  output logic                         memReadM,
  output logic                         memWriteM,
  output logic                         stallF,
  output logic                         stallD,
  output logic                         flushD,
  output logic                         flushE,
  output logic                         stallM,
  output logic                         flushW,
  output armPkg::fwdSelT               forwardA,
  output armPkg::fwdSelT               forwardB
);
  import armPkg::*;

  logic [1:0] opD;
  logic [3:0] cmdD;
  logic       regWriteD, memReadD, memWriteD, branchD, flagSetD, aluSrcD, shiftEnD;
  aluOpT      aluOpD;
  logic       regWriteE, memReadE, memWriteE, branchE, flagSetE;
  condT       condE;
  logic       condPassE;
  flagsT      flagReg;
  logic       regWriteM;
  logic       loadUse;

  assign opD  = instrD[27:26];
  assign cmdD = instrD[24:21];

  // Decode
  always_comb begin
    regSrcD   = 2'b00;
    immSrcD   = immDp;
    aluSrcD   = 1'b0;
    aluOpD    = aluAdd;
    shiftEnD  = 1'b0;
    regWriteD = 1'b0;
    memReadD  = 1'b0;
    memWriteD = 1'b0;
    branchD   = 1'b0;
    flagSetD  = 1'b0;
    case (opD)
      opDp: begin
        aluSrcD   = instrD[25];
        shiftEnD  = !instrD[25];
        regWriteD = (cmdD != cmdCmp);
        flagSetD  = instrD[20] || (cmdD == cmdCmp);
        case (cmdD)
          cmdAdd:         aluOpD = aluAdd;
          cmdSub, cmdCmp: aluOpD = aluSub;
          cmdAnd:         aluOpD = aluAnd;
          cmdOrr:         aluOpD = aluOrr;
          cmdMov:         aluOpD = aluMov;
          default: begin
            regWriteD = 1'b0;
            flagSetD  = 1'b0;
          end
        endcase
      end
      opMem: begin
        // Bit 20 is L, bit 23 is U
        immSrcD    = immMem;
        aluSrcD    = 1'b1;
        aluOpD     = instrD[23] ? aluAdd : aluSub;
        regSrcD[1] = !instrD[20];
        regWriteD  = instrD[20];
        memReadD   = instrD[20];
        memWriteD  = !instrD[20];
      end
      opBranch: begin
        immSrcD    = immBranch;
        aluSrcD    = 1'b1;
        regSrcD[0] = 1'b1;
        branchD    = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Execute control
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteE <= 1'b0;
      memReadE  <= 1'b0;
      memWriteE <= 1'b0;
      branchE   <= 1'b0;
      flagSetE  <= 1'b0;
      aluSrcE   <= 1'b0;
      aluOpE    <= aluAdd;
      shiftEnE  <= 1'b0;
      condE     <= condEq;
    end else if (flushE) begin
      regWriteE <= 1'b0;
      memReadE  <= 1'b0;
      memWriteE <= 1'b0;
      branchE   <= 1'b0;
      flagSetE  <= 1'b0;
    end else if (!memBusy) begin
      regWriteE <= regWriteD;
      memReadE  <= memReadD;
      memWriteE <= memWriteD;
      branchE   <= branchD;
      flagSetE  <= flagSetD;
      aluSrcE   <= aluSrcD;
      aluOpE    <= aluOpD;
      shiftEnE  <= shiftEnD;
      condE     <= condT'(instrD[31:28]);
    end
  end

  always_comb begin
    case (condE)
      condEq:  condPassE = flagReg.z;
      condNe:  condPassE = !flagReg.z;
      condGe:  condPassE = (flagReg.n == flagReg.v);
      condLt:  condPassE = (flagReg.n != flagReg.v);
      condAl:  condPassE = 1'b1;
      default: condPassE = 1'b0;
    endcase
  end

  // Update once, on the cycle the instruction leaves execute
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagReg <= '0;
    end else if (flagSetE && condPassE && !memBusy) begin
      flagReg <= flagsE;
    end
  end

  assign branchTakenE = branchE && condPassE;

  // Memory and writeback control
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memReadM  <= 1'b0;
      memWriteM <= 1'b0;
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end else begin
      if (!stallM) begin
        regWriteM <= regWriteE && condPassE;
        memReadM  <= memReadE && condPassE;
        memWriteM <= memWriteE && condPassE;
      end
      regWriteW <= !flushW && regWriteM;
      memToRegW <= !flushW && memReadM;
    end
  end

  // Hazards, memory stage has priority over writeback
  always_comb begin
    if (match1EM && regWriteM) begin
      forwardA = fwdAluOutM;
    end else if (match1EW && regWriteW) begin
      forwardA = fwdResultW;
    end else begin
      forwardA = fwdReg;
    end
    if (match2EM && regWriteM) begin
      forwardB = fwdAluOutM;
    end else if (match2EW && regWriteW) begin
      forwardB = fwdResultW;
    end else begin
      forwardB = fwdReg;
    end
  end

  assign loadUse = matchDE && memReadE;
  assign stallF  = loadUse || memBusy;
  assign stallD  = loadUse || memBusy;
  assign flushD  = branchTakenE && !memBusy;
  assign flushE  = (loadUse || branchTakenE) && !memBusy;
  assign stallM  = memBusy;
  assign flushW  = memBusy;

endmodule

`default_nettype wire

/* src/memBridge.sv */
`timescale 1ns/1ns
`default_nettype none

module memBridge (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         memReadM,
  input  logic                         memWriteM,
  input  logic [busPkg::addrWidth-1:0] addrM,
  input  logic [busPkg::dataWidth-1:0] writeDataM,
  input  logic [busPkg::dataWidth-1:0] wbDatI,
  input  logic                         wbAck,
  output logic                         wbCyc,
  output logic                         wbStb,
  output logic                         wbWe,
  output logic [busPkg::addrWidth-1:0] wbAdr,
  output logic [busPkg::dataWidth-1:0] wbDatO,
  output logic [busPkg::dataWidth-1:0] readDataM,
  output logic                         memBusy
);

  typedef enum logic {stIdle, stWait} stateT;

  stateT state;
  logic  request;

  assign request = memReadM || memWriteM;
  assign wbCyc   = (state == stWait);
  assign wbStb   = wbCyc;

  // Busy from the first memory-stage cycle until ack
  assign memBusy = (state == stIdle) ? request : !wbAck;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= stIdle;
      wbWe  <= 1'b0;
    end else if (state == stIdle && request) begin
      state <= stWait;
      wbWe  <= memWriteM;
    end else if (state == stWait && wbAck) begin
      state <= stIdle;
      wbWe  <= 1'b0;
    end
  end

  // Bus payload and load data
  always_ff @(posedge clk) begin
    if (state == stIdle && request) begin
      wbAdr  <= addrM;
      wbDatO <= writeDataM;
    end
    if (state == stWait && wbAck && !wbWe) begin
      readDataM <= wbDatI;
    end
  end

endmodule

`default_nettype wire

/* src/armCore.sv */
`timescale 1ns/1ns
`default_nettype none

module armCore (
  input  logic                         clk,
  input  logic                         rstN,
  output logic [busPkg::addrWidth-1:0] imemAddr,
  input  logic [busPkg::dataWidth-1:0] imemData,
  output logic                         wbCyc,
  output logic                         wbStb,
  output logic                         wbWe,
  output logic [busPkg::addrWidth-1:0] wbAdr,
  output logic [busPkg::dataWidth-1:0] wbDatO,
  input  logic [busPkg::dataWidth-1:0] wbDatI,
  input  logic                         wbAck
);
  import armPkg::*;
  import busPkg::*;

  logic [dataWidth-1:0] instrD, aluOutM, writeDataM, readDataM;
  immSrcT               immSrcD;
  logic [1:0]           regSrcD;
  logic                 aluSrcE, shiftEnE, branchTakenE;
  aluOpT                aluOpE;
  logic                 regWriteW, memToRegW, memReadM, memWriteM;
  logic                 stallF, stallD, flushD, flushE, stallM, flushW;
  fwdSelT               forwardA, forwardB;
  flagsT                flagsE;
  logic                 match1EM, match1EW, match2EM, match2EW, matchDE;
  logic                 memBusy;

  datapath dp (
    .clk          (clk),
    .rstN         (rstN),
    .instrF       (imemData),
    .immSrcD      (immSrcD),
    .regSrcD      (regSrcD),
    .aluSrcE      (aluSrcE),
    .aluOpE       (aluOpE),
    .shiftEnE     (shiftEnE),
    .branchTakenE (branchTakenE),
    .regWriteW    (regWriteW),
    .memToRegW    (memToRegW),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD),
    .flushE       (flushE),
    .stallM       (stallM),
    .flushW       (flushW),
    .forwardA     (forwardA),
    .forwardB     (forwardB),
    .readDataM    (readDataM),
    .pcF          (imemAddr),
    .instrD       (instrD),
    .aluOutM      (aluOutM),
    .writeDataM   (writeDataM),
    .flagsE       (flagsE),
    .match1EM     (match1EM),
    .match1EW     (match1EW),
    .match2EM     (match2EM),
    .match2EW     (match2EW),
    .matchDE      (matchDE)
  );

  controller ctrl (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .flagsE       (flagsE),
    .match1EM     (match1EM),
    .match1EW     (match1EW),
    .match2EM     (match2EM),
    .match2EW     (match2EW),
    .matchDE      (matchDE),
    .memBusy      (memBusy),
    .immSrcD      (immSrcD),
    .regSrcD      (regSrcD),
    .aluSrcE      (aluSrcE),
    .aluOpE       (aluOpE),
    .shiftEnE     (shiftEnE),
    .branchTakenE (branchTakenE),
    .regWriteW    (regWriteW),
    .memToRegW    (memToRegW),
    .memReadM     (memReadM),
    .memWriteM    (memWriteM),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD),
    .flushE       (flushE),
    .stallM       (stallM),
    .flushW       (flushW),
    .forwardA     (forwardA),
    .forwardB     (forwardB)
  );

  memBridge bridge (
    .clk        (clk),
    .rstN       (rstN),
    .memReadM   (memReadM),
    .memWriteM  (memWriteM),
    .addrM      (aluOutM),
    .writeDataM (writeDataM),
    .wbDatI     (wbDatI),
    .wbAck      (wbAck),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbWe       (wbWe),
    .wbAdr      (wbAdr),
    .wbDatO     (wbDatO),
    .readDataM  (readDataM),
    .memBusy    (memBusy)
  );

endmodule

`default_nettype wire

/* verif/storeMonitor.sv */
`timescale 1ns/1ns
`default_nettype none

module storeMonitor (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         wbCyc,
  input  logic                         wbStb,
  input  logic                         wbWe,
  input  logic                         wbAck,
  input  logic [busPkg::addrWidth-1:0] wbAdr,
  input  logic [busPkg::dataWidth-1:0] wbDatO,
  input  logic [31:0]                  expAdr [0:15],
  input  logic [31:0]                  expDat [0:15],
  input  int                           expCount,
  output int                           writesSeen,
  output int                           errorCount
);

  // A write completes on the edge where ack is sampled
  always @(posedge clk) begin
    if (wbCyc && wbStb && wbWe && wbAck) begin
      if (!rstN) begin
        $display("Wishbone write to %h completed while reset was asserted", wbAdr);
        errorCount <= errorCount + 1;
      end else if (writesSeen >= expCount) begin
        $display("Unexpected Wishbone write to %h with data %h after the last expected store",
                 wbAdr, wbDatO);
        errorCount <= errorCount + 1;
      end else if (wbAdr !== expAdr[writesSeen] || wbDatO !== expDat[writesSeen]) begin
        $display("ERROR store%0d: expected adr %h data %h, actual adr %h data %h",
                 writesSeen, expAdr[writesSeen], expDat[writesSeen], wbAdr, wbDatO);
        errorCount <= errorCount + 1;
      end
      writesSeen <= writesSeen + 1;
    end
  end

endmodule

`default_nettype wire

/* verif/armCore_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module armCore_checker (
  input logic                         clk,
  input logic                         rstN,
  input logic                         wbCyc,
  input logic                         wbStb,
  input logic                         wbWe,
  input logic                         wbAck,
  input logic                         memReadM,
  input logic                         memWriteM,
  input logic [busPkg::addrWidth-1:0] addrM,
  input logic [busPkg::addrWidth-1:0] wbAdr,
  input logic [busPkg::dataWidth-1:0] wbDatO
);

  stbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc)
    else $error("stb high without cyc");

  // Payload held until the slave answers
  payloadStable: assert property (@(posedge clk) disable iff (!rstN)
    (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe) && $stable(wbDatO)))
    else $error("adr, we or dato changed while waiting for ack");

  cycIdleInReset: assert property (@(posedge clk) !rstN |-> !wbCyc)
    else $error("cyc high during reset");

  // Stalled memory stage keeps presenting the same access
  accessHeldWhileWaiting: assert property (@(posedge clk) disable iff (!rstN)
    (wbStb && !wbAck) |-> ((memReadM || memWriteM) && wbAdr == addrM))
    else $error("memory-stage access not held while a bus cycle waits for ack");

endmodule

bind memBridge armCore_checker busChecks (.*);

`default_nettype wire

/* verif/tbArmCore.sv */
`timescale 1ns/1ns
`default_nettype none

module tbArmCore;
  import busPkg::*;

  localparam int clkPeriod   = 40;
  localparam int resetCycles = 8;
  localparam int driveDelay  = 2;

  logic                 clk;
  logic                 rstN;
  logic [addrWidth-1:0] imemAddr;
  logic [dataWidth-1:0] imemData;
  logic                 wbCyc;
  logic                 wbStb;
  logic                 wbWe;
  logic [addrWidth-1:0] wbAdr;
  logic [dataWidth-1:0] wbDatO;
  logic [dataWidth-1:0] wbDatI = '0;
  logic                 wbAck = 1'b0;

  // Vector image split into program, data and expected stores
  logic [31:0] vecs [0:255];
  logic [31:0] rom [0:63];
  logic [31:0] ram [0:15];
  logic [31:0] expAdr [0:15];
  logic [31:0] expDat [0:15];
  int          progLen;
  int          expCount;
  integer      seed;
  int          waitLeft;
  logic        pending;
  logic        loaded;
  longint      limitNs;
  int          writesSeen;
  int          errorCount;

  armCore i_dut (
    .clk      (clk),
    .rstN     (rstN),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbWe     (wbWe),
    .wbAdr    (wbAdr),
    .wbDatO   (wbDatO),
    .wbDatI   (wbDatI),
    .wbAck    (wbAck)
  );

  storeMonitor monitor (
    .clk        (clk),
    .rstN       (rstN),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbWe       (wbWe),
    .wbAck      (wbAck),
    .wbAdr      (wbAdr),
    .wbDatO     (wbDatO),
    .expAdr     (expAdr),
    .expDat     (expDat),
    .expCount   (expCount),
    .writesSeen (writesSeen),
    .errorCount (errorCount)
  );

  // Instruction ROM answers in the same cycle
  assign imemData = rom[imemAddr[7:2]];

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    seed     = 10430;
    rstN     = 1'b0;
    loaded   = 1'b0;
    pending  = 1'b0;
    waitLeft = 0;
    for (int i = 0; i < 256; i++) begin
      vecs[i] = {16'hA5A5, i[15:0]};
    end
    // Condition 1111 never passes, so unused ROM words act as bubbles
    for (int i = 0; i < 64; i++) begin
      rom[i] = {4'hF, 28'(i)};
    end
    $readmemh("verif/armVectors.mem", vecs);
    progLen  = (vecs[0] > 48) ? 48 : int'(vecs[0]);
    expCount = (vecs[1] > 16) ? 16 : int'(vecs[1]);
    for (int i = 0; i < progLen; i++) begin
      rom[i] = vecs[16 + i];
    end
    for (int i = 0; i < 16; i++) begin
      ram[i]    = vecs[64 + i];
      expAdr[i] = vecs[96 + 2 * i];
      expDat[i] = vecs[97 + 2 * i];
    end
    limitNs = longint'(progLen + expCount) * 10 * clkPeriod + resetCycles * clkPeriod;
    loaded  = 1'b1;

    repeat (resetCycles) @(posedge clk);
    #(driveDelay) rstN = 1'b1;

    wait (writesSeen >= expCount);
    // Quiet window catches any write past the last expected store
    repeat (20) @(posedge clk);

    $display("Stores seen %0d of %0d, errors %0d", writesSeen, expCount, errorCount);
    if (errorCount == 0 && writesSeen == expCount) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Wishbone slave with 0 to 3 wait states before ack
  always @(posedge clk) begin
    #(driveDelay);
    if (wbAck) begin
      wbAck = 1'b0;
    end else if (wbCyc && wbStb) begin
      if (!pending) begin
        pending  = 1'b1;
        waitLeft = $random(seed) & 3;
      end
      if (waitLeft == 0) begin
        if (wbWe) begin
          ram[wbAdr[5:2]] = wbDatO;
        end else begin
          wbDatI = ram[wbAdr[5:2]];
        end
        wbAck   = 1'b1;
        pending = 1'b0;
      end else begin
        waitLeft = waitLeft - 1;
      end
    end
  end

  initial begin
    wait (loaded);
    #(limitNs);
    $display("Timeout after %0d ns with %0d of %0d stores seen and %0d errors",
             limitNs, writesSeen, expCount, errorCount);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/armVectors.mem */
// @00 program length and expected store count, @10 program words
// @40 data RAM words, @60 expected stores as address then data
@00
0000001D 00000006
@10
E3A01C01 E3A0200F E3A034FF E0824202
E5814000 E0445443 E5815004 E20560FF
E1867263 E5817008 E1A08C23 E5919020
E089A008 E581A00C E352000F 0A000002
E581203C E581303C E581403C 1A000002
E5818010 E3520010 AA000002 BA000002
E581203C E581303C E581403C E5817014
EAFFFFFE
@40
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
12345678 00000000 00000000 00000000
00000000 00000000 00000000 00000000
@60
00000100 000000FF
00000104 000100FF
00000108 0FF000FF
0000010C 12345777
00000110 000000FF
00000114 0FF000FF

/* files.f */
common/busPkg.sv
common/armPkg.sv
datapath/regFile.sv
datapath/execUnit.sv
datapath/datapath.sv
src/controller.sv
src/memBridge.sv
src/armCore.sv
verif/storeMonitor.sv
verif/armCore_checker.sv
verif/tbArmCore.sv

/* run.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbArmCore \
  -f files.f -o simArmCore
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simArmCore > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Verification failed" "$logFile"; then
  exit 1
fi
exit 0
